/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module mipsCpuBusTb -f src.f -o simv

out=$(./obj_dir/simv 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* sim/busMemory.sv */
module busMemory (
    input  logic          EXEC1,
    input  logic          rstN,
    input  logic          randomWaits,
    input  cpuPkg::word_t address,
    input  logic          read,
    input  logic          write,
    input  cpuPkg::word_t writeData,
    output cpuPkg::word_t readData,
    output logic          waitRequest,
    output int            strayCount
);

    // Words kept in bus byte order, 4 KB window at the reset vector
    cpuPkg::word_t mem [1024];

    logic [31:0]   lfsr;
    logic          inXfer;
    logic          xferWrite;
    cpuPkg::word_t xferAddr;
    cpuPkg::word_t xferData;
    int            waitLeft;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Zero to three wait cycles, one LFSR step per bit
    task automatic drawWaits(output int n);
        logic [1:0] bits;
        lfsr = lfsrStep(lfsr);
        bits[0] = lfsr[0];
        lfsr = lfsrStep(lfsr);
        bits[1] = lfsr[0];
        n = {30'd0, bits};
    endtask

    initial begin
        readData    = '0;
        waitRequest = 1'b0;
        strayCount  = 0;
        inXfer      = 1'b0;
        xferWrite   = 1'b0;
        waitLeft    = 0;
        lfsr        = 32'h2558_7972;
    end

    // ------------------------------------------------------------------------
    // Slave side, updated just after each rising edge
    // ------------------------------------------------------------------------
    always @(posedge EXEC1) begin
        #1;
        if (!rstN) begin
            inXfer   = 1'b0;
            waitLeft = 0;
        end else begin
            // waitRequest still shows the cycle that just ended
            if (inXfer && !waitRequest) begin
                if (xferWrite) begin
                    mem[xferAddr[11:2]] = xferData;
                end
                inXfer = 1'b0;
            end else if (inXfer) begin
                waitLeft = waitLeft - 1;
            end
            // New request seen on the bus
            if (!inXfer && (read || write)) begin
                inXfer    = 1'b1;
                xferWrite = write;
                xferAddr  = address;
                xferData  = writeData;
                if (address[31:12] != 20'hBFC00) begin
                    strayCount = strayCount + 1;
                end
                if (randomWaits) begin
                    drawWaits(waitLeft);
                end else begin
                    waitLeft = 0;
                end
            end
        end
        waitRequest = inXfer && (waitLeft != 0);
        readData    = (inXfer && !xferWrite) ? mem[xferAddr[11:2]] : '0;
    end

endmodule

/* sim/mipsCpuBusTb.sv */
module mipsCpuBusTb;

    localparam int halfPeriod  = 10;
    localparam int resetCycles = 8;
    localparam int driveDelay  = 2;
    localparam int quietCycles = 4;

    // Program lengths in instructions
    localparam int arithLen  = 31;
    localparam int memLen    = 9;
    localparam int branchLen = 15;
    localparam int jumpLen   = 6;
    localparam int testRuns  = 7;
    // First three programs run twice
    localparam int totalInstrs = 2 * (arithLen + memLen + branchLen) + jumpLen;
    // Two transfers per instruction with up to three waits each
    localparam int maxWaitPerInstr = 6;
    localparam int timeoutCycles = 2 * (totalInstrs * (6 + maxWaitPerInstr) +
                                        testRuns * (resetCycles + quietCycles + 2));

    logic          EXEC1;
    logic          rstN;
    logic          randomWaits;
    logic          waitRequest;
    logic          read;
    logic          write;
    logic          active;
    cpuPkg::word_t readData;
    cpuPkg::word_t address;
    cpuPkg::word_t writeData;
    cpuPkg::word_t regV0;
    int            strayCount;
    int            errorCount;
    int            checkCount;
    int            cycleCount;

    mipsCpuBus i_mipsCpuBus (
        .EXEC1(EXEC1), .rstN(rstN), .waitRequest(waitRequest), .readData(readData),
        .address(address), .read(read), .write(write), .writeData(writeData),
        .active(active), .regV0(regV0)
    );

    busMemory memModel (
        .EXEC1(EXEC1), .rstN(rstN), .randomWaits(randomWaits), .address(address),
        .read(read), .write(write), .writeData(writeData), .readData(readData),
        .waitRequest(waitRequest), .strayCount(strayCount)
    );

    always #halfPeriod EXEC1 = ~EXEC1;

    // ------------------------------------------------------------------------
    // Instruction encoders and helpers
    // ------------------------------------------------------------------------
    function automatic cpuPkg::word_t rType(input int rs, input int rt, input int rd,
                                            input int sh, input cpuPkg::opcode_t fn);
        return {cpuPkg::opSpecial, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic cpuPkg::word_t iType(input cpuPkg::opcode_t op, input int rs,
                                            input int rt, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // J keeps the top PC nibble
    function automatic cpuPkg::word_t jumpTo(input cpuPkg::word_t target);
        return {cpuPkg::opJ, target[27:2]};
    endfunction

    // Bus side is little endian
    function automatic cpuPkg::word_t toBusOrder(input cpuPkg::word_t w);
        cpuPkg::word_t b;
        for (int i = 0; i < 4; i++) begin
            b[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return b;
    endfunction

    function automatic cpuPkg::word_t memAt(input cpuPkg::word_t addr);
        return memModel.mem[addr[11:2]];
    endfunction

    task automatic checkValue(input string name, input cpuPkg::word_t got,
                              input cpuPkg::word_t expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic putWord(input cpuPkg::word_t addr, input cpuPkg::word_t value);
        memModel.mem[addr[11:2]] = toBusOrder(value);
    endtask

    // Clears the window and places the program at the reset vector
    task automatic loadProgram(input cpuPkg::word_t prog[$]);
        for (int i = 0; i < 1024; i++) begin
            putWord(cpuPkg::resetVector + 4 * i, '0);
        end
        for (int i = 0; i < prog.size(); i++) begin
            putWord(cpuPkg::resetVector + 4 * i, prog[i]);
        end
    endtask

    // Reset low for resetCycles edges with memory loaded in between
    task automatic startReset(input logic rnd);
        @(posedge EXEC1);
        #driveDelay;
        rstN = 1'b0;
        randomWaits = rnd;
        repeat (2) @(posedge EXEC1);
        #driveDelay;
    endtask

    task automatic endReset;
        repeat (resetCycles - 2) @(posedge EXEC1);
        #driveDelay;
        rstN = 1'b1;
    endtask

    // Active rises one cycle after reset release and the bus stays idle after halt
    task automatic waitForHalt;
        repeat (2) @(negedge EXEC1);
        checkValue("active", {31'd0, active}, 32'd1);
        while (active) @(negedge EXEC1);
        repeat (quietCycles) begin
            @(negedge EXEC1);
            checkValue("read", {31'd0, read}, '0);
            checkValue("write", {31'd0, write}, '0);
        end
    endtask

    // Never both strobes in one cycle
    always @(negedge EXEC1) begin
        if (rstN) begin
            checkValue("read & write", {31'd0, read & write}, '0);
        end
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic arithTest(input logic rnd);
        cpuPkg::word_t prog[$];
        cpuPkg::word_t r8, r9, r10, r11, r14, r15, r16, r17, r18, r19;
        cpuPkg::word_t r21, r22, r23, r24, r25, expV0;
        startReset(rnd);
        prog.push_back(iType(cpuPkg::opAddiu, 0, 8, 100));
        prog.push_back(iType(cpuPkg::opAddiu, 0, 9, -7));
        prog.push_back(rType(8, 9, 10, 0, cpuPkg::fnAddu));
        prog.push_back(rType(9, 8, 11, 0, cpuPkg::fnSubu));
        prog.push_back(rType(10, 11, 12, 0, cpuPkg::fnAnd));
        prog.push_back(rType(10, 11, 13, 0, cpuPkg::fnOr));
        prog.push_back(rType(12, 13, 14, 0, cpuPkg::fnXor));
        prog.push_back(rType(11, 8, 15, 0, cpuPkg::fnSlt));
        prog.push_back(rType(11, 8, 16, 0, cpuPkg::fnSltu));
        prog.push_back(rType(0, 10, 17, 4, cpuPkg::fnSll));
        prog.push_back(rType(0, 11, 18, 2, cpuPkg::fnSra));
        prog.push_back(rType(0, 11, 19, 28, cpuPkg::fnSrl));
        prog.push_back(iType(cpuPkg::opAddiu, 0, 20, 3));
        prog.push_back(rType(20, 10, 21, 0, cpuPkg::fnSllv));
        prog.push_back(rType(20, 11, 22, 0, cpuPkg::fnSrav));
        prog.push_back(rType(20, 9, 23, 0, cpuPkg::fnSrlv));
        prog.push_back(iType(cpuPkg::opAndi, 11, 24, 'hFF0F));
        prog.push_back(iType(cpuPkg::opSlti, 11, 25, -100));
        // Fold everything into v0
        prog.push_back(rType(14, 15, 2, 0, cpuPkg::fnAddu));
        prog.push_back(rType(2, 16, 2, 0, cpuPkg::fnAddu));
        prog.push_back(rType(2, 17, 2, 0, cpuPkg::fnXor));
        prog.push_back(rType(2, 18, 2, 0, cpuPkg::fnAddu));
        prog.push_back(rType(2, 19, 2, 0, cpuPkg::fnXor));
        prog.push_back(rType(2, 21, 2, 0, cpuPkg::fnSubu));
        prog.push_back(rType(2, 22, 2, 0, cpuPkg::fnXor));
        prog.push_back(rType(2, 23, 2, 0, cpuPkg::fnAddu));
        prog.push_back(rType(2, 24, 2, 0, cpuPkg::fnXor));
        prog.push_back(rType(2, 25, 2, 0, cpuPkg::fnAddu));
        // Unsupported MUL and MULT aimed at v0
        prog.push_back({6'b011100, 5'd8, 5'd9, 5'd2, 5'd0, 6'b000010});
        prog.push_back(rType(8, 9, 2, 0, 6'b011000));
        prog.push_back(rType(0, 0, 0, 0, cpuPkg::fnJr));
        loadProgram(prog);
        endReset();
        waitForHalt();
        // Reference values by MIPS rules
        r8  = 32'd100;
        r9  = 32'hFFFF_FFF9;
        r10 = r8 + r9;
        r11 = r9 - r8;
        r14 = (r10 & r11) ^ (r10 | r11);
        r15 = ($signed(r11) < $signed(r8)) ? 32'd1 : 32'd0;
        r16 = (r11 < r8) ? 32'd1 : 32'd0;
        r17 = r10 << 4;
        r18 = $signed(r11) >>> 2;
        r19 = r11 >> 28;
        r21 = r10 << 3;
        r22 = $signed(r11) >>> 3;
        r23 = r9 >> 3;
        r24 = r11 & 32'h0000_FF0F;
        r25 = ($signed(r11) < -32'sd100) ? 32'd1 : 32'd0;
        expV0 = r14 + r15;
        expV0 = expV0 + r16;
        expV0 = expV0 ^ r17;
        expV0 = expV0 + r18;
        expV0 = expV0 ^ r19;
        expV0 = expV0 - r21;
        expV0 = expV0 ^ r22;
        expV0 = expV0 + r23;
        expV0 = expV0 ^ r24;
        expV0 = expV0 + r25;
        checkValue("regV0", regV0, expV0);
    endtask

    // Data area at BFC00200
    task automatic memoryTest(input logic rnd);
        cpuPkg::word_t prog[$];
        startReset(rnd);
        prog.push_back(iType(cpuPkg::opLui, 0, 8, 'hBFC0));
        prog.push_back(iType(cpuPkg::opOri, 8, 8, 'h0200));
        prog.push_back(iType(cpuPkg::opLui, 0, 9, 'h1234));
        prog.push_back(iType(cpuPkg::opOri, 9, 9, 'hABCD));
        prog.push_back(iType(cpuPkg::opSw, 8, 9, 4));
        prog.push_back(iType(cpuPkg::opLw, 8, 2, 4));
        prog.push_back(iType(cpuPkg::opLw, 8, 3, 8));
        prog.push_back(iType(cpuPkg::opSw, 8, 3, -4));
        prog.push_back(rType(0, 0, 0, 0, cpuPkg::fnJr));
        loadProgram(prog);
        putWord(32'hBFC0_0208, 32'hCAFE_F00D);
        endReset();
        waitForHalt();
        checkValue("regV0", regV0, {16'h1234, 16'hABCD});
        checkValue("mem[bfc00204]", memAt(32'hBFC0_0204), toBusOrder(32'h1234_ABCD));
        checkValue("mem[bfc001fc]", memAt(32'hBFC0_01FC), toBusOrder(32'hCAFE_F00D));
    endtask

    // Each marker adds its own bit to v0
    task automatic branchTest(input logic rnd);
        cpuPkg::word_t prog[$];
        startReset(rnd);
        prog.push_back(iType(cpuPkg::opAddiu, 0, 2, 0));
        prog.push_back(iType(cpuPkg::opAddiu, 0, 8, 5));
        prog.push_back(iType(cpuPkg::opAddiu, 0, 9, 5));
        prog.push_back(iType(cpuPkg::opAddiu, 0, 10, 6));
        prog.push_back(iType(cpuPkg::opBeq, 8, 9, 1));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 1));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 2));
        prog.push_back(iType(cpuPkg::opBne, 8, 9, 1));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 4));
        prog.push_back(iType(cpuPkg::opBeq, 8, 10, 1));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 8));
        prog.push_back(iType(cpuPkg::opBne, 8, 10, 1));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 16));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 32));
        prog.push_back(rType(0, 0, 0, 0, cpuPkg::fnJr));
        loadProgram(prog);
        endReset();
        waitForHalt();
        // Taken branches skip markers 1 and 16
        checkValue("regV0", regV0, 32'd2 + 32'd4 + 32'd8 + 32'd32);
    endtask

    task automatic jumpTest(input logic rnd);
        cpuPkg::word_t prog[$];
        startReset(rnd);
        prog.push_back(iType(cpuPkg::opAddiu, 0, 2, 1));
        prog.push_back(jumpTo(cpuPkg::resetVector + 32'd16));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 2));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 4));
        prog.push_back(iType(cpuPkg::opAddiu, 2, 2, 8));
        prog.push_back(rType(0, 0, 0, 0, cpuPkg::fnJr));
        loadProgram(prog);
        endReset();
        waitForHalt();
        checkValue("regV0", regV0, 32'd1 + 32'd8);
    endtask

    // ------------------------------------------------------------------------
    // Watchdog and main sequence
    // ------------------------------------------------------------------------
    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge EXEC1);
            cycleCount++;
        end
        $display("Error: no result after %0d cycles, the run was stopped", timeoutCycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        EXEC1       = 1'b0;
        rstN        = 1'b0;
        randomWaits = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        arithTest(1'b0);
        memoryTest(1'b0);
        branchTest(1'b0);
        jumpTest(1'b0);
        // Same programs under random wait states
        arithTest(1'b1);
        memoryTest(1'b1);
        branchTest(1'b1);
        if (strayCount != 0) begin
            $display("Error: %0d bus accesses fell outside the test memory", strayCount);
            errorCount += strayCount;
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src.f */
verilog/cpuPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/busMaster.sv
verilog/fetchDecode.sv
verilog/controlSequencer.sv
verilog/mipsCpuBus.sv
sim/busMemory.sv
sim/mipsCpuBusTb.sv

/* verilog/alu.sv */
module alu (
    input  cpuPkg::word_t  opA,
    input  cpuPkg::word_t  opB,
    input  cpuPkg::shamt_t shamt,
    input  cpuPkg::aluOp_t aluOp,
    output cpuPkg::word_t  result,
    output logic           equal
);

    // Shifts act on opB, the rt operand
    always_comb begin
        case (aluOp)
            cpuPkg::add:   result = opA + opB;
            cpuPkg::sub:   result = opA - opB;
            cpuPkg::andOp: result = opA & opB;
            cpuPkg::orOp:  result = opA | opB;
            cpuPkg::xorOp: result = opA ^ opB;
            cpuPkg::slt:   result = {31'd0, $signed(opA) < $signed(opB)};
            cpuPkg::sltu:  result = {31'd0, opA < opB};
            cpuPkg::sll:   result = opB << shamt;
            cpuPkg::srl:   result = opB >> shamt;
            cpuPkg::sra:   result = $signed(opB) >>> shamt;
            cpuPkg::lui:   result = {opB[15:0], 16'h0000};
            default:       result = opA + opB;
        endcase
    end

    // BEQ and BNE
    assign equal = (opA == opB);

endmodule

/* verilog/busMaster.sv */
module busMaster (
    input  logic            EXEC1,
    input  logic            rstN,
    input  logic            busStart,
    input  cpuPkg::busReq_t busReq,
    input  logic            waitRequest,
    output cpuPkg::word_t   address,
    output logic            read,
    output logic            write,
    output cpuPkg::word_t   writeData,
    output logic            busDone
);

    // Transfer ends on the first edge without wait
    assign busDone = (read || write) && !waitRequest;

    // ------------------------------------------------------------------------
    // Request registers
    // ------------------------------------------------------------------------
    always_ff @(posedge EXEC1) begin
        if (!rstN) begin
            read  <= 1'b0;
            write <= 1'b0;
        end else if (busStart) begin
            read  <= (busReq.kind == cpuPkg::rd);
            write <= (busReq.kind == cpuPkg::wr);
        end else if (busDone) begin
            read  <= 1'b0;
            write <= 1'b0;
        end
    end

    // Address and data only move on a new request
    always_ff @(posedge EXEC1) begin
        if (busStart) begin
            address   <= busReq.addr;
            writeData <= cpuPkg::byteSwap(busReq.data);
        end
    end

    // A new request never overlaps a pending one
    assert property (@(posedge EXEC1) disable iff (!rstN)
        busStart |-> !read && !write);

    // Slave sees a frozen request while it stalls
    assert property (@(posedge EXEC1) disable iff (!rstN)
        (read || write) && waitRequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writeData));

endmodule

/* verilog/controlSequencer.sv */
module controlSequencer (
    input  logic             EXEC1,
    input  logic             rstN,
    input  cpuPkg::decoded_t instr,
    input  cpuPkg::word_t    loadWord,
    input  logic             busDone,
    input  cpuPkg::word_t    rsData,
    input  cpuPkg::word_t    rtData,
    input  cpuPkg::word_t    aluResult,
    input  logic             aluEqual,
    output logic             busStart,
    output cpuPkg::busReq_t  busReq,
    output logic             captureInstr,
    output cpuPkg::regIdx_t  rsIdx,
    output cpuPkg::regIdx_t  rtIdx,
    output logic             wrEn,
    output cpuPkg::regIdx_t  wrIdx,
    output cpuPkg::word_t    wrData,
    output cpuPkg::word_t    opA,
    output cpuPkg::word_t    opB,
    output cpuPkg::shamt_t   shamt,
    output cpuPkg::aluOp_t   aluOp,
    output logic             active
);

    cpuPkg::seqState_t state;
    cpuPkg::seqState_t nextState;
    cpuPkg::word_t     pc;
    cpuPkg::word_t     pcPlus4;
    cpuPkg::word_t     nextPc;
    logic              isMem;
    logic              useImm;
    logic              haltNow;

    assign isMem   = (instr.kind == cpuPkg::load) || (instr.kind == cpuPkg::store);
    assign useImm  = isMem || (instr.kind == cpuPkg::aluImm);
    assign haltNow = (instr.kind == cpuPkg::jumpReg) && (rsData == cpuPkg::haltAddr);

    // ------------------------------------------------------------------------
    // Operands and writeback
    // ------------------------------------------------------------------------
    assign rsIdx = instr.rs;
    assign rtIdx = instr.rt;
    assign opA   = rsData;
    // Loads and stores reuse the adder for rs plus offset
    assign opB   = useImm ? instr.imm : rtData;
    assign shamt = instr.useShamtReg ? rsData[4:0] : instr.shamt;
    assign aluOp = instr.aluOp;

    assign wrEn   = (state == cpuPkg::execB) &&
                    (instr.kind == cpuPkg::aluReg || instr.kind == cpuPkg::aluImm ||
                     instr.kind == cpuPkg::load);
    assign wrIdx  = instr.dest;
    assign wrData = (instr.kind == cpuPkg::load) ? loadWord : aluResult;

    // Bus requests
    assign captureInstr = (state == cpuPkg::fetchWait);
    assign busStart     = (state == cpuPkg::fetch) || (state == cpuPkg::execA && isMem);

    always_comb begin
        busReq.addr = aluResult;
        busReq.data = rtData;
        busReq.kind = cpuPkg::idle;
        if (state == cpuPkg::fetch) begin
            busReq.addr = pc;
            busReq.kind = cpuPkg::rd;
        end else if (busStart) begin
            busReq.kind = (instr.kind == cpuPkg::load) ? cpuPkg::rd : cpuPkg::wr;
        end
    end

    // ------------------------------------------------------------------------
    // Next PC without delay slot
    // ------------------------------------------------------------------------
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        nextPc = pcPlus4;
        case (instr.kind)
            cpuPkg::branchEq: if (aluEqual) nextPc = pcPlus4 + {instr.imm[29:0], 2'b00};
            cpuPkg::branchNe: if (!aluEqual) nextPc = pcPlus4 + {instr.imm[29:0], 2'b00};
            cpuPkg::jump:     nextPc = {pc[31:28], instr.target26, 2'b00};
            cpuPkg::jumpReg:  nextPc = rsData;
            default:          nextPc = pcPlus4;
        endcase
    end

    // State machine
    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::fetch:     nextState = cpuPkg::fetchWait;
            cpuPkg::fetchWait: if (busDone) nextState = cpuPkg::execA;
            cpuPkg::execA:     nextState = isMem ? cpuPkg::memWait : cpuPkg::execB;
            cpuPkg::memWait:   if (busDone) nextState = cpuPkg::execB;
            cpuPkg::execB:     nextState = haltNow ? cpuPkg::halted : cpuPkg::fetch;
            default:           nextState = cpuPkg::halted;
        endcase
    end

    always_ff @(posedge EXEC1) begin
        if (!rstN) begin
            state  <= cpuPkg::fetch;
            pc     <= cpuPkg::resetVector;
            active <= 1'b0;
        end else begin
            state  <= nextState;
            active <= (nextState != cpuPkg::halted);
            if (state == cpuPkg::execB) begin
                pc <= nextPc;
            end
        end
    end

    // Completions only come back while a transfer is awaited
    assert property (@(posedge EXEC1) disable iff (!rstN)
        busDone |-> (state == cpuPkg::fetchWait) || (state == cpuPkg::memWait));

    // The bus moves whole words only
    assert property (@(posedge EXEC1) disable iff (!rstN)
        busStart |-> (busReq.addr[1:0] == 2'b00));

endmodule

/* verilog/cpuPkg.sv */
package cpuPkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;

    localparam word_t   resetVector = 32'hBFC00000;
    localparam word_t   haltAddr    = 32'h00000000;
    localparam regIdx_t regV0Idx    = 5'd2;

    // Primary opcodes
    localparam opcode_t opSpecial = 6'b000000;
    localparam opcode_t opJ       = 6'b000010;
    localparam opcode_t opBeq     = 6'b000100;
    localparam opcode_t opBne     = 6'b000101;
    localparam opcode_t opAddiu   = 6'b001001;
    localparam opcode_t opSlti    = 6'b001010;
    localparam opcode_t opSltiu   = 6'b001011;
    localparam opcode_t opAndi    = 6'b001100;
    localparam opcode_t opOri     = 6'b001101;
    localparam opcode_t opXori    = 6'b001110;
    localparam opcode_t opLui     = 6'b001111;
    localparam opcode_t opLw      = 6'b100011;
    localparam opcode_t opSw      = 6'b101011;

    // Funct field of SPECIAL
    localparam opcode_t fnSll  = 6'b000000;
    localparam opcode_t fnSrl  = 6'b000010;
    localparam opcode_t fnSra  = 6'b000011;
    localparam opcode_t fnSllv = 6'b000100;
    localparam opcode_t fnSrlv = 6'b000110;
    localparam opcode_t fnSrav = 6'b000111;
    localparam opcode_t fnJr   = 6'b001000;
    localparam opcode_t fnAddu = 6'b100001;
    localparam opcode_t fnSubu = 6'b100011;
    localparam opcode_t fnAnd  = 6'b100100;
    localparam opcode_t fnOr   = 6'b100101;
    localparam opcode_t fnXor  = 6'b100110;
    localparam opcode_t fnSlt  = 6'b101010;
    localparam opcode_t fnSltu = 6'b101011;

    // ------------------------------------------------------------------------
    // Decoded instruction and bus request
    // ------------------------------------------------------------------------
    // Nine kinds, so four bits
    typedef enum logic [3:0] {
        aluReg, aluImm, load, store, branchEq, branchNe, jump, jumpReg, nop
    } instrKind_t;

    typedef enum logic [3:0] {
        add, sub, andOp, orOp, xorOp, slt, sltu, sll, srl, sra, lui
    } aluOp_t;

    typedef struct packed {
        instrKind_t  kind;
        aluOp_t      aluOp;
        regIdx_t     rs;
        regIdx_t     rt;
        regIdx_t     dest;
        shamt_t      shamt;
        logic        useShamtReg;
        word_t       imm;
        logic [25:0] target26;
    } decoded_t;

    typedef enum logic [1:0] {idle, rd, wr} busKind_t;

    typedef struct packed {
        busKind_t kind;
        word_t    addr;
        word_t    data;
    } busReq_t;

    typedef enum logic [2:0] {
        fetch, fetchWait, execA, memWait, execB, halted
    } seqState_t;

    // Bus words are little endian, the core works big endian
    function automatic word_t byteSwap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

/* verilog/fetchDecode.sv */
module fetchDecode (
    input  logic             EXEC1,
    input  logic             rstN,
    input  cpuPkg::word_t    readData,
    input  logic             busDone,
    input  logic             captureInstr,
    output cpuPkg::decoded_t instr,
    output cpuPkg::word_t    loadWord
);

    cpuPkg::word_t   instrWord;
    cpuPkg::opcode_t opcode;
    cpuPkg::opcode_t funct;
    cpuPkg::word_t   immSext;
    cpuPkg::word_t   immZext;

    // ------------------------------------------------------------------------
    // Capture of completed reads
    // ------------------------------------------------------------------------
    // Cleared IR decodes as SLL $0 which writes nothing useful
    always_ff @(posedge EXEC1) begin
        if (!rstN) begin
            instrWord <= '0;
        end else if (busDone && captureInstr) begin
            instrWord <= cpuPkg::byteSwap(readData);
        end
    end

    // Load data register
    always_ff @(posedge EXEC1) begin
        if (busDone && !captureInstr) begin
            loadWord <= cpuPkg::byteSwap(readData);
        end
    end

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    assign opcode  = instrWord[31:26];
    assign funct   = instrWord[5:0];
    assign immSext = {{16{instrWord[15]}}, instrWord[15:0]};
    assign immZext = {16'h0000, instrWord[15:0]};

    always_comb begin
        instr.kind        = cpuPkg::nop;
        instr.aluOp       = cpuPkg::add;
        instr.rs          = instrWord[25:21];
        instr.rt          = instrWord[20:16];
        instr.dest        = instrWord[20:16];
        instr.shamt       = instrWord[10:6];
        instr.useShamtReg = 1'b0;
        instr.imm         = immSext;
        instr.target26    = instrWord[25:0];
        if (opcode == cpuPkg::opSpecial) begin
            // R-type writes rd
            instr.dest = instrWord[15:11];
            instr.kind = cpuPkg::aluReg;
            case (funct)
                cpuPkg::fnAddu: instr.aluOp = cpuPkg::add;
                cpuPkg::fnSubu: instr.aluOp = cpuPkg::sub;
                cpuPkg::fnAnd:  instr.aluOp = cpuPkg::andOp;
                cpuPkg::fnOr:   instr.aluOp = cpuPkg::orOp;
                cpuPkg::fnXor:  instr.aluOp = cpuPkg::xorOp;
                cpuPkg::fnSlt:  instr.aluOp = cpuPkg::slt;
                cpuPkg::fnSltu: instr.aluOp = cpuPkg::sltu;
                cpuPkg::fnSll:  instr.aluOp = cpuPkg::sll;
                cpuPkg::fnSrl:  instr.aluOp = cpuPkg::srl;
                cpuPkg::fnSra:  instr.aluOp = cpuPkg::sra;
                cpuPkg::fnJr:   instr.kind  = cpuPkg::jumpReg;
                // Variable shifts take the amount from rs
                cpuPkg::fnSllv, cpuPkg::fnSrlv, cpuPkg::fnSrav: begin
                    instr.useShamtReg = 1'b1;
                    instr.aluOp = (funct == cpuPkg::fnSllv) ? cpuPkg::sll :
                                  (funct == cpuPkg::fnSrlv) ? cpuPkg::srl : cpuPkg::sra;
                end
                default:        instr.kind  = cpuPkg::nop;
            endcase
        end else begin
            instr.kind = cpuPkg::aluImm;
            case (opcode)
                cpuPkg::opAddiu: instr.aluOp = cpuPkg::add;
                cpuPkg::opSlti:  instr.aluOp = cpuPkg::slt;
                cpuPkg::opSltiu: instr.aluOp = cpuPkg::sltu;
                cpuPkg::opLui:   instr.aluOp = cpuPkg::lui;
                cpuPkg::opLw:    instr.kind  = cpuPkg::load;
                cpuPkg::opSw:    instr.kind  = cpuPkg::store;
                cpuPkg::opBeq:   instr.kind  = cpuPkg::branchEq;
                cpuPkg::opBne:   instr.kind  = cpuPkg::branchNe;
                cpuPkg::opJ:     instr.kind  = cpuPkg::jump;
                default:         instr.kind  = cpuPkg::nop;
            endcase
            // Logical immediates are zero extended
            if (opcode == cpuPkg::opAndi || opcode == cpuPkg::opOri ||
                opcode == cpuPkg::opXori) begin
                instr.imm   = immZext;
                instr.kind  = cpuPkg::aluImm;
                instr.aluOp = (opcode == cpuPkg::opAndi) ? cpuPkg::andOp :
                              (opcode == cpuPkg::opOri)  ? cpuPkg::orOp  : cpuPkg::xorOp;
            end
        end
    end

endmodule

/* verilog/mipsCpuBus.sv */
module mipsCpuBus (
    input  logic           EXEC1,
    input  logic           rstN,
    input  logic           waitRequest,
    input  cpuPkg::word_t  readData,
    output cpuPkg::word_t  address,
    output logic           read,
    output logic           write,
    output cpuPkg::word_t  writeData,
    output logic           active,
    output cpuPkg::word_t  regV0
);

    // Sequencer to bus side
    logic            busStart;
    logic            busDone;
    logic            captureInstr;
    cpuPkg::busReq_t busReq;

    // Decoded instruction and load data
    cpuPkg::decoded_t instr;
    cpuPkg::word_t    loadWord;

    // Register file ports
    cpuPkg::regIdx_t rsIdx;
    cpuPkg::regIdx_t rtIdx;
    cpuPkg::regIdx_t wrIdx;
    logic            wrEn;
    cpuPkg::word_t   wrData;
    cpuPkg::word_t   rsData;
    cpuPkg::word_t   rtData;

    // ALU ports
    cpuPkg::word_t   opA;
    cpuPkg::word_t   opB;
    cpuPkg::shamt_t  shamt;
    cpuPkg::aluOp_t  aluOp;
    cpuPkg::word_t   aluResult;
    logic            aluEqual;

    fetchDecode i_fetchDecode (
        .EXEC1(EXEC1), .rstN(rstN), .readData(readData), .busDone(busDone),
        .captureInstr(captureInstr), .instr(instr), .loadWord(loadWord)
    );

    controlSequencer i_controlSequencer (
        .EXEC1(EXEC1), .rstN(rstN), .instr(instr), .loadWord(loadWord),
        .busDone(busDone), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .aluEqual(aluEqual), .busStart(busStart),
        .busReq(busReq), .captureInstr(captureInstr), .rsIdx(rsIdx),
        .rtIdx(rtIdx), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
        .opA(opA), .opB(opB), .shamt(shamt), .aluOp(aluOp), .active(active)
    );

    regFile i_regFile (
        .EXEC1(EXEC1), .rstN(rstN), .rsIdx(rsIdx), .rtIdx(rtIdx),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
        .rsData(rsData), .rtData(rtData), .regV0(regV0)
    );

    alu i_alu (
        .opA(opA), .opB(opB), .shamt(shamt), .aluOp(aluOp),
        .result(aluResult), .equal(aluEqual)
    );

    busMaster i_busMaster (
        .EXEC1(EXEC1), .rstN(rstN), .busStart(busStart), .busReq(busReq),
        .waitRequest(waitRequest), .address(address), .read(read),
        .write(write), .writeData(writeData), .busDone(busDone)
    );

endmodule

/* verilog/regFile.sv */
module regFile (
    input  logic            EXEC1,
    input  logic            rstN,
    input  cpuPkg::regIdx_t rsIdx,
    input  cpuPkg::regIdx_t rtIdx,
    input  logic            wrEn,
    input  cpuPkg::regIdx_t wrIdx,
    input  cpuPkg::word_t   wrData,
    output cpuPkg::word_t   rsData,
    output cpuPkg::word_t   rtData,
    output cpuPkg::word_t   regV0
);

    cpuPkg::word_t regs [32];

    // Entry zero is never written so it stays cleared
    always_ff @(posedge EXEC1) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != 5'd0) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Combinational reads
    assign rsData = (rsIdx == 5'd0) ? '0 : regs[rsIdx];
    assign rtData = (rtIdx == 5'd0) ? '0 : regs[rtIdx];
    assign regV0  = regs[cpuPkg::regV0Idx];

endmodule
